/* Bender.yml */
package:
  name: tiny_core

sources:
  - files:
      - design/tiny_pkg.sv
      - design/tiny_decoder.sv
      - design/tiny_alu.sv
      - design/tiny_regfile.sv
      - design/tiny_sequencer.sv
      - design/tiny_core.sv
  - target: test
    files:
      - test/tiny_core_checker.sv
      - test/tiny_core_tb.sv

/* compile.f */
design/tiny_pkg.sv
design/tiny_decoder.sv
design/tiny_alu.sv
design/tiny_regfile.sv
design/tiny_sequencer.sv
design/tiny_core.sv
test/tiny_core_checker.sv
test/tiny_core_tb.sv

/* design/tiny_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module tiny_alu import tiny_pkg::*; #(
    parameter bit HAS_SLT = 1'b1
) (
    input  logic            main_clk,
    input  logic            nreset,
    input  logic            enable,
    input  alu_op_t         op,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [XLEN-1:0] result,
    output logic            zero,
    output logic            carry,
    output logic            lt
);

    logic [XLEN:0] diff;
    logic signed_lt;
    logic [XLEN-1:0] next_result;

    // Borrow out of the subtraction doubles as unsigned less-than
    assign diff = {1'b0, a} - {1'b0, b};
    assign signed_lt = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            ALU_ADD: next_result = a + b;
            ALU_SUB: next_result = diff[XLEN-1:0];
            ALU_SLL: next_result = a << b[4:0];
            ALU_SLT: next_result = HAS_SLT ? {{(XLEN-1){1'b0}}, signed_lt} : '0;
            ALU_SLTU: next_result = HAS_SLT ? {{(XLEN-1){1'b0}}, diff[XLEN]} : '0;
            ALU_XOR: next_result = a ^ b;
            ALU_SRL: next_result = a >> b[4:0];
            ALU_SRA: next_result = $signed(a) >>> b[4:0];
            ALU_OR: next_result = a | b;
            ALU_AND: next_result = a & b;
            default: next_result = '0;
        endcase
    end

    always_ff @(posedge main_clk) begin
        if (!nreset) begin
            carry <= 1'b0;
            lt <= 1'b0;
        end else if (enable) begin
            carry <= diff[XLEN];
            lt <= signed_lt;
        end
    end

    always_ff @(posedge main_clk) begin
        if (enable) begin
            result <= next_result;
        end
    end

    assign zero = result == '0;

endmodule

`default_nettype wire

/* design/tiny_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tiny_core import tiny_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0,
    parameter bit              HAS_SLT = 1'b1
) (
    input  logic              main_clk,
    input  logic              nreset,
    output logic [XLEN-1:0]   address,
    input  logic [XLEN-1:0]   data_in,
    output logic [XLEN-1:0]   data_out,
    output logic              nrd,
    output logic [STRB_W-1:0] nwr,
    input  logic              ready,
    output logic              halted,
    output logic              error
);

    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] pc;
    stage_t stage;
    logic alu_enable;
    op1_src_t op1_src;
    op2_src_t op2_src;
    alu_op_t alu_op;
    wb_src_t wb_src;
    pc_src_t pc_src;
    logic reg_write;
    logic load;
    logic store;
    logic is_ebreak;
    logic illegal;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_result;
    logic zero;
    logic carry;
    logic lt;
    logic [REG_AW-1:0] rd_addr;
    logic [XLEN-1:0] rd_data;
    logic rd_we;

    // Operand isolation outside EXECUTE
    always_comb begin
        op_a = '0;
        op_b = '0;
        if (stage == EXECUTE) begin
            case (op1_src)
                OP1_RS1: op_a = rs1_data;
                OP1_PC: op_a = pc;
                default: op_a = '0;
            endcase
            op_b = op2_src == OP2_IMM ? imm : rs2_data;
        end
    end

    tiny_sequencer #(
        .RESET_PC(RESET_PC)
    ) tiny_sequencer_i (
        .main_clk(main_clk),
        .nreset(nreset),
        .ready(ready),
        .data_in(data_in),
        .instr(instr),
        .pc(pc),
        .stage(stage),
        .alu_enable(alu_enable),
        .load(load),
        .store(store),
        .reg_write(reg_write),
        .wb_src(wb_src),
        .pc_src(pc_src),
        .is_ebreak(is_ebreak),
        .illegal(illegal),
        .imm(imm),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .alu_result(alu_result),
        .zero(zero),
        .carry(carry),
        .lt(lt),
        .funct3(instr[14:12]),
        .rd_addr(rd_addr),
        .rd_data(rd_data),
        .rd_we(rd_we),
        .address(address),
        .data_out(data_out),
        .nrd(nrd),
        .nwr(nwr),
        .halted(halted),
        .error(error)
    );

    tiny_decoder #(
        .HAS_SLT(HAS_SLT)
    ) tiny_decoder_i (
        .instr(instr),
        .op1_src(op1_src),
        .op2_src(op2_src),
        .alu_op(alu_op),
        .wb_src(wb_src),
        .pc_src(pc_src),
        .reg_write(reg_write),
        .load(load),
        .store(store),
        .is_ebreak(is_ebreak),
        .illegal(illegal),
        .imm(imm)
    );

    tiny_alu #(
        .HAS_SLT(HAS_SLT)
    ) tiny_alu_i (
        .main_clk(main_clk),
        .nreset(nreset),
        .enable(alu_enable),
        .op(alu_op),
        .a(op_a),
        .b(op_b),
        .result(alu_result),
        .zero(zero),
        .carry(carry),
        .lt(lt)
    );

    tiny_regfile tiny_regfile_i (
        .main_clk(main_clk),
        .rs1_addr(instr[19:15]),
        .rs2_addr(instr[24:20]),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .rd_addr(rd_addr),
        .rd_data(rd_data),
        .rd_we(rd_we)
    );

endmodule

`default_nettype wire

/* design/tiny_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module tiny_decoder import tiny_pkg::*; #(
    parameter bit HAS_SLT = 1'b1
) (
    input  logic [XLEN-1:0] instr,
    output op1_src_t        op1_src,
    output op2_src_t        op2_src,
    output alu_op_t         alu_op,
    output wb_src_t         wb_src,
    output pc_src_t         pc_src,
    output logic            reg_write,
    output logic            load,
    output logic            store,
    output logic            is_ebreak,
    output logic            illegal,
    output logic [XLEN-1:0] imm
);

    opcode_t opcode;
    logic [FUNCT3_W-1:0] funct3;
    logic f7_zero;
    logic f7_alt;
    logic slt_bad;
    logic op_ok;
    logic op_imm_ok;
    alu_op_t arith_op;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;

    assign opcode = opcode_t'(instr[6:2]);
    assign funct3 = instr[14:12];

    // funct7 reduced to the two encodings RV32I uses
    assign f7_zero = instr[31:25] == 7'b0000000;
    assign f7_alt = instr[31:25] == 7'b0100000;

    assign slt_bad = !HAS_SLT && (funct3 == 3'b010 || funct3 == 3'b011);
    assign op_ok = f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
    assign op_imm_ok = funct3 == 3'b001 ? f7_zero :
                       funct3 == 3'b101 ? (f7_zero || f7_alt) : 1'b1;

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'h000};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        case (funct3)
            3'b000: arith_op = (opcode == OPC_OP && f7_alt) ? ALU_SUB : ALU_ADD;
            3'b001: arith_op = ALU_SLL;
            3'b010: arith_op = ALU_SLT;
            3'b011: arith_op = ALU_SLTU;
            3'b100: arith_op = ALU_XOR;
            3'b101: arith_op = f7_alt ? ALU_SRA : ALU_SRL;
            3'b110: arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        op1_src = OP1_RS1;
        op2_src = OP2_RS2;
        alu_op = ALU_ADD;
        wb_src = WB_ALU;
        pc_src = PC_PLUS4;
        reg_write = 1'b0;
        load = 1'b0;
        store = 1'b0;
        is_ebreak = 1'b0;
        illegal = 1'b0;
        imm = imm_i;
        case (opcode)
            OPC_OP: begin
                alu_op = arith_op;
                reg_write = 1'b1;
                illegal = !op_ok || slt_bad;
            end
            OPC_OP_IMM: begin
                op2_src = OP2_IMM;
                alu_op = arith_op;
                reg_write = 1'b1;
                illegal = !op_imm_ok || slt_bad;
            end
            OPC_LUI, OPC_AUIPC: begin
                op1_src = opcode == OPC_LUI ? OP1_ZERO : OP1_PC;
                op2_src = OP2_IMM;
                reg_write = 1'b1;
                imm = imm_u;
            end
            OPC_LOAD: begin
                wb_src = WB_LOAD;
                reg_write = 1'b1;
                load = 1'b1;
                illegal = funct3 != 3'b010;
            end
            OPC_STORE: begin
                store = 1'b1;
                imm = imm_s;
                illegal = funct3 != 3'b010;
            end
            OPC_BRANCH: begin
                // Compare by subtraction with flags kept by the ALU
                alu_op = ALU_SUB;
                pc_src = PC_BRANCH;
                imm = imm_b;
                illegal = funct3 == 3'b010 || funct3 == 3'b011;
            end
            OPC_JAL: begin
                wb_src = WB_PC4;
                pc_src = PC_JAL;
                reg_write = 1'b1;
                imm = imm_j;
            end
            OPC_JALR: begin
                wb_src = WB_PC4;
                pc_src = PC_JALR;
                reg_write = 1'b1;
                illegal = funct3 != 3'b000;
            end
            OPC_SYSTEM: begin
                is_ebreak = instr == EBREAK_WORD;
                illegal = instr != EBREAK_WORD;
            end
            default: illegal = 1'b1;
        endcase
        if (instr[1:0] != 2'b11) begin
            illegal = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* design/tiny_pkg.sv */
`default_nettype none

package tiny_pkg;

    localparam int XLEN = 32;
    localparam int REG_AW = 5;
    localparam int FUNCT3_W = 3;
    localparam int STRB_W = 4;

    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

    // Major opcodes from instruction bits 6 to 2
    typedef enum logic [4:0] {
        OPC_LOAD   = 5'b00000,
        OPC_OP_IMM = 5'b00100,
        OPC_AUIPC  = 5'b00101,
        OPC_STORE  = 5'b01000,
        OPC_OP     = 5'b01100,
        OPC_LUI    = 5'b01101,
        OPC_BRANCH = 5'b11000,
        OPC_JALR   = 5'b11001,
        OPC_JAL    = 5'b11011,
        OPC_SYSTEM = 5'b11100
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    typedef enum logic [1:0] {OP1_RS1, OP1_PC, OP1_ZERO} op1_src_t;

    typedef enum logic {OP2_RS2, OP2_IMM} op2_src_t;

    typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_PC4} wb_src_t;

    typedef enum logic [1:0] {PC_PLUS4, PC_BRANCH, PC_JAL, PC_JALR} pc_src_t;

    typedef enum logic [2:0] {
        WRITEBACK,
        FETCH,
        DECODE,
        EXECUTE,
        SET_PC
    } stage_t;

endpackage

`default_nettype wire

/* design/tiny_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module tiny_regfile import tiny_pkg::*; (
    input  logic              main_clk,
    input  logic [REG_AW-1:0] rs1_addr,
    input  logic [REG_AW-1:0] rs2_addr,
    output logic [XLEN-1:0]   rs1_data,
    output logic [XLEN-1:0]   rs2_data,
    input  logic [REG_AW-1:0] rd_addr,
    input  logic [XLEN-1:0]   rd_data,
    input  logic              rd_we
);

    logic [XLEN-1:0] regs [0:2**REG_AW-1];

    always_ff @(posedge main_clk) begin
        if (rd_we && rd_addr != '0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // x0 never written, so force zero on read
    always_ff @(posedge main_clk) begin
        rs1_data <= rs1_addr == '0 ? '0 : regs[rs1_addr];
        rs2_data <= rs2_addr == '0 ? '0 : regs[rs2_addr];
    end

endmodule

`default_nettype wire

/* design/tiny_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module tiny_sequencer import tiny_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic                main_clk,
    input  logic                nreset,
    input  logic                ready,
    input  logic [XLEN-1:0]     data_in,
    output logic [XLEN-1:0]     instr,
    output logic [XLEN-1:0]     pc,
    output stage_t              stage,
    output logic                alu_enable,
    input  logic                load,
    input  logic                store,
    input  logic                reg_write,
    input  wb_src_t             wb_src,
    input  pc_src_t             pc_src,
    input  logic                is_ebreak,
    input  logic                illegal,
    input  logic [XLEN-1:0]     imm,
    input  logic [XLEN-1:0]     rs1_data,
    input  logic [XLEN-1:0]     rs2_data,
    input  logic [XLEN-1:0]     alu_result,
    input  logic                zero,
    input  logic                carry,
    input  logic                lt,
    input  logic [FUNCT3_W-1:0] funct3,
    output logic [REG_AW-1:0]   rd_addr,
    output logic [XLEN-1:0]     rd_data,
    output logic                rd_we,
    output logic [XLEN-1:0]     address,
    output logic [XLEN-1:0]     data_out,
    output logic                nrd,
    output logic [STRB_W-1:0]   nwr,
    output logic                halted,
    output logic                error
);

    logic run;
    logic mem_access;
    logic pc_misaligned;
    logic data_misaligned;
    logic take_branch;
    logic wb_pending;
    logic [XLEN-1:0] data_addr;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] next_pc;
    logic [XLEN-1:0] load_data;
    logic [XLEN-1:0] wb_data;

    assign run = !halted && !error;
    assign mem_access = load || store;
    assign pc_plus4 = pc + 32'd4;
    assign pc_misaligned = pc[1:0] != 2'b00;
    assign data_addr = rs1_data + imm;
    assign data_misaligned = data_addr[1:0] != 2'b00;

    // Bus strobes held until ready completes the transfer
    assign address = (stage == EXECUTE && mem_access) ? data_addr : pc;
    assign data_out = rs2_data;
    assign nrd = !(run && ((stage == FETCH && !pc_misaligned) ||
                           (stage == EXECUTE && load && !data_misaligned)));
    assign nwr = (run && stage == EXECUTE && store && !data_misaligned) ? '0 : '1;

    assign alu_enable = run && stage == EXECUTE;

    assign rd_addr = instr[11:7];
    assign rd_data = wb_data;
    assign rd_we = run && stage == WRITEBACK && wb_pending;

    always_comb begin
        case (funct3)
            3'b000: take_branch = zero;
            3'b001: take_branch = !zero;
            3'b100: take_branch = lt;
            3'b101: take_branch = !lt;
            3'b110: take_branch = carry;
            3'b111: take_branch = !carry;
            default: take_branch = 1'b0;
        endcase
    end

    always_comb begin
        case (pc_src)
            PC_BRANCH: next_pc = take_branch ? pc + imm : pc_plus4;
            PC_JAL: next_pc = pc + imm;
            PC_JALR: next_pc = (rs1_data + imm) & ~32'h1;
            default: next_pc = pc_plus4;
        endcase
    end

    always_ff @(posedge main_clk) begin
        if (!nreset) begin
            stage <= WRITEBACK;
            pc <= RESET_PC;
            wb_pending <= 1'b0;
            halted <= 1'b0;
            error <= 1'b0;
        end else if (run) begin
            case (stage)
                WRITEBACK: begin
                    wb_pending <= 1'b0;
                    stage <= FETCH;
                end
                FETCH: begin
                    if (pc_misaligned) begin
                        error <= 1'b1;
                    end else if (ready) begin
                        stage <= DECODE;
                    end
                end
                DECODE: begin
                    if (illegal) begin
                        error <= 1'b1;
                    end else if (is_ebreak) begin
                        halted <= 1'b1;
                    end else begin
                        stage <= EXECUTE;
                    end
                end
                EXECUTE: begin
                    if (!mem_access) begin
                        stage <= SET_PC;
                    end else if (data_misaligned) begin
                        error <= 1'b1;
                    end else if (ready) begin
                        stage <= SET_PC;
                    end
                end
                default: begin
                    pc <= next_pc;
                    wb_pending <= reg_write;
                    stage <= WRITEBACK;
                end
            endcase
        end
    end

    always_ff @(posedge main_clk) begin
        if (run && stage == FETCH && ready && !pc_misaligned) begin
            instr <= data_in;
        end
        if (stage == EXECUTE && load && ready) begin
            load_data <= data_in;
        end
        // Link value taken before pc moves
        if (stage == SET_PC) begin
            case (wb_src)
                WB_LOAD: wb_data <= load_data;
                WB_PC4: wb_data <= pc_plus4;
                default: wb_data <= alu_result;
            endcase
        end
    end

endmodule

`default_nettype wire

/* test/tiny_core_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tiny_core_checker (
    input logic        main_clk,
    input logic        nreset,
    input logic [31:0] address,
    input logic [31:0] data_out,
    input logic        nrd,
    input logic [3:0]  nwr,
    input logic        ready,
    input logic        halted,
    input logic        error
);

    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] want_addr;
    logic [31:0] want_data;
    string test_name;
    int test_errors;
    int error_count = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    task automatic begin_test(input string name);
        test_name = name;
        test_errors = 0;
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic flag_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
        test_errors++;
        error_count++;
    endtask

    task automatic flag_text(input string msg);
        $display("%s: %s", test_name, msg);
        test_errors++;
        error_count++;
    endtask

    // A store completes on the edge where ready is seen with nwr low
    always @(posedge main_clk) begin
        if (nreset) begin
            if ((halted || error) && (nrd !== 1'b1 || nwr !== 4'hf)) begin
                flag_text("bus strobe active after the core stopped");
            end else if (ready && nwr === 4'h0) begin
                if (exp_addr.size() == 0) begin
                    flag_text("store seen that the model did not expect");
                end else begin
                    want_addr = exp_addr.pop_front();
                    want_data = exp_data.pop_front();
                    if (address !== want_addr) flag_value("store address", want_addr, address);
                    if (data_out !== want_data) flag_value("store data", want_data, data_out);
                end
            end else if (nwr !== 4'h0 && nwr !== 4'hf) begin
                flag_text("partial byte write strobes on a word store");
            end
        end
    end

    task automatic end_test(input logic exp_halted, input logic exp_error);
        if (exp_addr.size() != 0) begin
            flag_text($sformatf("%0d expected stores never appeared", exp_addr.size()));
        end
        if (halted !== exp_halted) flag_value("halted", 32'(exp_halted), 32'(halted));
        if (error !== exp_error) flag_value("error", 32'(exp_error), 32'(error));
        if (test_errors == 0) begin
            tests_passed++;
            $display("PASS %s", test_name);
        end else begin
            tests_failed++;
            $display("FAIL %s with %0d errors", test_name, test_errors);
        end
    endtask

    task automatic report();
        $display("Tests passed %0d, failed %0d, errors %0d",
                 tests_passed, tests_failed, error_count);
    endtask

endmodule

`default_nettype wire

/* test/tiny_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module tiny_core_tb;

    logic main_clk;
    logic nreset;
    logic [31:0] data_in;
    logic ready;
    logic [31:0] address;
    logic [31:0] data_out;
    logic nrd;
    logic [3:0] nwr;
    logic halted;
    logic error;

    logic [31:0] mem [0:1023];
    logic [31:0] model_mem [0:1023];
    logic [31:0] prog [$];
    integer seed = 70;
    int max_wait;
    int wait_left;
    int cycle_count = 0;
    int cycle_limit = 200;

    tiny_core #(
        .RESET_PC(32'h0),
        .HAS_SLT(1'b1)
    ) tiny_core_i (
        .main_clk(main_clk),
        .nreset(nreset),
        .address(address),
        .data_in(data_in),
        .data_out(data_out),
        .nrd(nrd),
        .nwr(nwr),
        .ready(ready),
        .halted(halted),
        .error(error)
    );

    tiny_core_checker tiny_core_checker_i (
        .main_clk(main_clk),
        .nreset(nreset),
        .address(address),
        .data_out(data_out),
        .nrd(nrd),
        .nwr(nwr),
        .ready(ready),
        .halted(halted),
        .error(error)
    );

    always #10 main_clk = !main_clk;

    always @(posedge main_clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles, the core did not halt", cycle_count);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic int rand_below(input int n);
        return {$random(seed)} % n;
    endfunction

    // Memory responder with random wait states
    always @(posedge main_clk) begin
        #1;
        if (!nreset || ready) begin
            ready = 1'b0;
            wait_left = max_wait == 0 ? 0 : rand_below(max_wait + 1);
        end else if (!nrd || nwr == 4'h0) begin
            if (wait_left == 0) begin
                ready = 1'b1;
                if (!nrd) data_in = mem[address[11:2]];
                else mem[address[11:2]] = data_out;
            end else begin
                wait_left--;
            end
        end
    end

    function automatic logic [31:0] enc_r(input int f7, rs2, rs1, f3, rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input int imm, rs1, f3, rd, opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] enc_s(input int imm, rs2, rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(input int imm, rs2, rs1, f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_u(input int imm, rd, opc);
        return {imm[19:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] enc_j(input int imm, rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    // Reference arithmetic from the RV32I definitions
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? $signed(a) >>> b[4:0] : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic run_model(output int steps, output logic halt_o, output logic err_o);
        logic [31:0] r [0:31];
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] imm_i;
        logic [31:0] next;
        logic write;
        r[0] = '0;
        pc = '0;
        steps = 0;
        halt_o = 1'b0;
        err_o = 1'b0;
        while (!halt_o && !err_o && steps < 2000) begin
            ins = model_mem[pc[11:2]];
            steps++;
            a = r[ins[19:15]];
            b = r[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            next = pc + 4;
            write = 1'b1;
            res = '0;
            case (ins[6:0])
                7'h33: res = alu_ref(ins[14:12], ins[30], a, b);
                7'h13: res = alu_ref(ins[14:12], ins[14:12] == 3'd5 && ins[30], a, imm_i);
                7'h37: res = {ins[31:12], 12'h0};
                7'h17: res = pc + {ins[31:12], 12'h0};
                7'h03: begin
                    addr = a + imm_i;
                    err_o = addr[1:0] != 2'b00;
                    res = model_mem[addr[11:2]];
                end
                7'h23: begin
                    addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    write = 1'b0;
                    err_o = addr[1:0] != 2'b00;
                    if (!err_o) begin
                        model_mem[addr[11:2]] = b;
                        tiny_core_checker_i.expect_store(addr, b);
                    end
                end
                7'h63: begin
                    write = 1'b0;
                    if (branch_taken(ins[14:12], a, b)) begin
                        next = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                    end
                end
                7'h6f: begin
                    res = pc + 4;
                    next = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                7'h67: begin
                    res = pc + 4;
                    next = (a + imm_i) & ~32'h1;
                end
                default: begin
                    write = 1'b0;
                    halt_o = ins == 32'h0010_0073;
                    err_o = !halt_o;
                end
            endcase
            if (write && !err_o && ins[11:7] != 5'd0) r[ins[11:7]] = res;
            pc = next;
        end
    endtask

    task automatic init_regs();
        for (int i = 1; i < 8; i++) begin
            prog.push_back(enc_u(rand_below(1 << 20), i, 7'h37));
            prog.push_back(enc_i(rand_below(4096), i, 0, i, 7'h13));
        end
    endtask

    task automatic store_regs();
        for (int i = 0; i < 8; i++) prog.push_back(enc_s(32'h400 + 4 * i, i, 0));
    endtask

    task automatic run_test(input string name, input int waits);
        int steps;
        logic exp_halted;
        logic exp_error;
        @(posedge main_clk);
        #1;
        nreset = 1'b0;
        max_wait = waits;
        tiny_core_checker_i.begin_test(name);
        for (int i = 0; i < 1024; i++) model_mem[i] = ~i;
        foreach (prog[i]) model_mem[i] = prog[i];
        mem = model_mem;
        run_model(steps, exp_halted, exp_error);
        cycle_limit += steps * 5 * 4;
        repeat (2) @(posedge main_clk);
        #1;
        nreset = 1'b1;
        wait (halted || error);
        // Extra cycles to catch strobes after the stop
        repeat (10) @(posedge main_clk);
        tiny_core_checker_i.end_test(exp_halted, exp_error);
    endtask

    initial begin
        int f3;
        int alt;
        main_clk = 1'b0;
        nreset = 1'b0;
        ready = 1'b0;
        data_in = '0;
        max_wait = 0;
        wait_left = 0;

        init_regs();
        repeat (12) begin
            f3 = rand_below(8);
            alt = (f3 == 0 || f3 == 5) ? rand_below(2) : 0;
            prog.push_back(enc_r(alt << 5, rand_below(8), rand_below(8), f3, rand_below(8)));
        end
        store_regs();
        prog.push_back(32'h0010_0073);
        run_test("reg_alu", 3);

        prog.delete();
        init_regs();
        repeat (12) begin
            f3 = rand_below(8);
            case (rand_below(3))
                0: prog.push_back(enc_i(f3 == 1 ? rand_below(32) :
                                        f3 == 5 ? (rand_below(2) << 10) | rand_below(32) :
                                        rand_below(4096), rand_below(8), f3, rand_below(8), 7'h13));
                1: prog.push_back(enc_u(rand_below(1 << 20), rand_below(8), 7'h37));
                default: prog.push_back(enc_u(rand_below(1 << 20), rand_below(8), 7'h17));
            endcase
        end
        store_regs();
        prog.push_back(32'h0010_0073);
        run_test("imm_alu", 3);

        prog.delete();
        init_regs();
        prog.push_back(enc_s(32'h500, 1, 0));
        prog.push_back(enc_i(32'h500, 0, 2, 2, 7'h03));
        prog.push_back(enc_s(32'h504, 2, 0));
        prog.push_back(32'h0010_0073);
        run_test("store_load", 3);

        prog.delete();
        init_regs();
        repeat (8) begin
            // Skip the two unused branch encodings
            f3 = rand_below(6);
            f3 = f3 < 2 ? f3 : f3 + 2;
            prog.push_back(enc_b(8, 1 + rand_below(3), 1 + rand_below(3), f3));
            prog.push_back(enc_i(rand_below(4096), 1, 0, 1 + rand_below(7), 7'h13));
        end
        prog.push_back(enc_j(8, 5));
        prog.push_back(enc_i(1, 1, 0, 1, 7'h13));
        prog.push_back(enc_u(0, 6, 7'h17));
        prog.push_back(enc_i(12, 6, 0, 7, 7'h67));
        prog.push_back(enc_i(1, 2, 0, 2, 7'h13));
        store_regs();
        prog.push_back(32'h0010_0073);
        run_test("branch_jump", 3);
        run_test("branch_jump_no_wait", 0);

        prog.delete();
        init_regs();
        prog.push_back(enc_s(32'h400, 1, 0));
        prog.push_back(32'hffff_ffff);
        prog.push_back(enc_s(32'h404, 2, 0));
        run_test("illegal", 3);

        prog.delete();
        init_regs();
        prog.push_back(enc_i(2, 0, 2, 3, 7'h03));
        prog.push_back(enc_s(32'h400, 3, 0));
        run_test("misaligned_lw", 3);

        tiny_core_checker_i.report();
        if (tiny_core_checker_i.error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
